/* build.f */
+incdir+source
source/lat_pkg.sv
source/req_fifo.sv
source/delay_gen.sv
source/slot_array.sv
source/flow_ctrl.sv
source/latency_model_top.sv
bench/latency_model_checker.sv
bench/latency_model_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the latency model testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
   --top-module latency_model_tb -o latency_model_sim

# A failing run exits nonzero, the log decides the result
./obj_dir/latency_model_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

/* bench/latency_model_tb.sv */
`timescale 1ns/1ps
`include "lat_params.svh"

module latency_model_tb;

   // Writes in total, read hold start, fence phase start
   localparam int N_REQ    = 400;
   localparam int HOLD_AT  = 150;
   localparam int FENCE_AT = 200;
   localparam logic [2:0] FENCE_CODE = lat_pkg::WRFENCE;

   logic                   clk;
   logic                   rst;
   lat_pkg::req_t          req_i;
   logic                   write_i;
   logic                   full_o;
   logic [`LAT_TID_W-1:0]  tid_o;
   logic [`LAT_META_W-1:0] meta_o;
   logic [`LAT_DATA_W-1:0] data_o;
   logic                   valid_o;
   logic                   read_i;
   logic                   empty_o;
   logic                   overflow_o;
   logic                   underflow_o;

   // Stimulus state
   logic [31:0]   rng;
   logic [2:0]    typ;
   lat_pkg::req_t next_req;
   int            n_issue;
   int            fence_gap;
   logic          hold_reads;
   logic          full_seen;

   // Reference model, indexed by expected tid
   logic [`LAT_META_W-1:0] exp_meta [N_REQ];
   logic [`LAT_DATA_W-1:0] exp_data [N_REQ];
   int                     wr_cyc [N_REQ];
   int                     epoch_of [N_REQ];
   int                     epoch_start [N_REQ+1];
   bit                     seen [N_REQ];
   int                     cyc;
   int                     n_acc;
   int                     n_tid;
   int                     n_fence;
   int                     n_seen;
   int                     low_unseen;
   int                     t;

   latency_model_top latency_model_top_i (
      .clk         (clk),
      .rst         (rst),
      .req_i       (req_i),
      .write_i     (write_i),
      .full_o      (full_o),
      .tid_o       (tid_o),
      .meta_o      (meta_o),
      .data_o      (data_o),
      .valid_o     (valid_o),
      .read_i      (read_i),
      .empty_o     (empty_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   bind latency_model_top latency_model_checker latency_model_checker_i (
      .clk         (clk),
      .rst         (rst),
      .read_i      (read_i),
      .valid_i     (valid_o),
      .empty_i     (empty_o),
      .full_i      (full_o),
      .overflow_i  (overflow_o),
      .underflow_i (underflow_o),
      .tid_i       (tid_o),
      .meta_i      (meta_o)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Shortest delay a type can draw
   function automatic int min_delay(input logic [2:0] code);
      case (code)
         lat_pkg::RDLINE: return `LAT_RDLINE_MIN;
         lat_pkg::WRLINE: return `LAT_WRLINE_MIN;
         lat_pkg::WRTHRU: return `LAT_WRTHRU_MIN;
         lat_pkg::INTR:   return `LAT_INTR_MIN;
         default:         return `LAT_UNDEF_DELAY;
      endcase
   endfunction

   task automatic fail_and_stop();
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic abort_run(input string why);
      $display("Error at %0t ns: %s", $time, why);
      fail_and_stop();
   endtask

   task automatic mismatch_stop(input string sig, input logic [63:0] exp,
                                input logic [63:0] got);
      $display("** Error at %0t ns: %s expected 'h%0h, got 'h%0h", $time, sig, exp, got);
      fail_and_stop();
   endtask

   always #2 clk = ~clk;

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      write_i    = 1'b0;
      read_i     = 1'b0;
      req_i      = '0;
      rng        = 32'hfcd8;
      n_issue    = 0;
      fence_gap  = 3;
      hold_reads = 1'b0;
      full_seen  = 1'b0;
      cyc        = 0;
      n_acc      = 0;
      n_tid      = 0;
      n_fence    = 0;
      n_seen     = 0;
      low_unseen = 0;
      epoch_start[0] = 0;
      for (int i = 0; i < N_REQ; i++) begin
         seen[i] = 1'b0;
      end
      repeat (8) @(posedge clk);
      rst <= 1'b0;
   end

   // Watchdog, generous per-request budget
   initial begin
      repeat (N_REQ * 40) @(posedge clk);
      abort_run("Timeout, not every request came out of the model");
   end

   // Writer and reader stimulus
   always @(posedge clk) begin
      if (!rst) begin
         rng = xorshift32(rng);
         // Random gaps, nothing while full_o is high
         if (n_issue < N_REQ && !full_o && rng[1:0] != 2'b00) begin
            rng = xorshift32(rng);
            typ = rng[2:0];
            if (typ == FENCE_CODE) begin
               typ = lat_pkg::INTR;
            end
            // Fence every two to five requests in the last phase
            if (n_issue >= FENCE_AT) begin
               if (fence_gap == 0) begin
                  typ       = FENCE_CODE;
                  fence_gap = 2 + int'(rng[9:8]);
               end else begin
                  fence_gap = fence_gap - 1;
               end
            end
            next_req.meta = {rng[31:19], typ};
            rng           = xorshift32(rng);
            next_req.data = rng;
            req_i   <= next_req;
            write_i <= 1'b1;
            n_issue = n_issue + 1;
         end else begin
            write_i <= 1'b0;
         end
         // Back-pressure stretch ends once full_o is seen
         hold_reads = (n_issue >= HOLD_AT) && !full_seen;
         if (hold_reads && full_o) begin
            full_seen  = 1'b1;
            hold_reads = 1'b0;
         end
         // Never two reads in a row, so valid_o is never stale
         rng = xorshift32(rng);
         read_i <= valid_o && !read_i && !hold_reads && (rng[2:0] != 3'd0);
      end
   end

   // Reference model and output checks
   always @(posedge clk) begin
      if (!rst) begin
         cyc = cyc + 1;
         if (write_i) begin
            n_acc = n_acc + 1;
            if (req_i.meta[2:0] == FENCE_CODE) begin
               // Later tids fall behind this fence
               n_fence = n_fence + 1;
               epoch_start[n_fence] = n_tid;
            end else begin
               exp_meta[n_tid] = req_i.meta;
               exp_data[n_tid] = req_i.data;
               wr_cyc[n_tid]   = cyc;
               epoch_of[n_tid] = n_fence;
               n_tid = n_tid + 1;
            end
         end
         if (read_i) begin
            assert (valid_o) else abort_run("read_i was high while valid_o was low");
            assert (int'(tid_o) < n_tid)
               else abort_run($sformatf("tid %0d was never handed out", tid_o));
            t = int'(tid_o);
            assert (!seen[t]) else abort_run($sformatf("tid %0d came out twice", t));
            assert (meta_o[2:0] != FENCE_CODE) else abort_run("a fence reached meta_o");
            assert (meta_o == exp_meta[t])
               else mismatch_stop("meta_o", 64'(exp_meta[t]), 64'(meta_o));
            assert (data_o == exp_data[t])
               else mismatch_stop("data_o", 64'(exp_data[t]), 64'(data_o));
            // Type minimum plus three cycles at the least
            assert (cyc - wr_cyc[t] >= min_delay(exp_meta[t][2:0]) + 3)
               else abort_run($sformatf("tid %0d left too early", t));
            // All tids before the preceding fence must be out
            assert (low_unseen >= epoch_start[epoch_of[t]])
               else abort_run($sformatf("tid %0d passed a fence ahead of tid %0d", t,
                                        low_unseen));
            seen[t] = 1'b1;
            n_seen  = n_seen + 1;
            while (low_unseen < n_tid && seen[low_unseen]) begin
               low_unseen = low_unseen + 1;
            end
         end
         if (n_acc == N_REQ && n_seen == n_tid) begin
            $display("STATUS: PASS");
            $finish;
         end
      end
   end

endmodule

/* bench/latency_model_checker.sv */
`timescale 1ns/1ps
`include "lat_params.svh"

// Concurrent checks on the latency model status and output head
module latency_model_checker (
   input logic                   clk,
   input logic                   rst,
   input logic                   read_i,
   input logic                   valid_i,
   input logic                   empty_i,
   input logic                   full_i,
   input logic                   overflow_i,
   input logic                   underflow_i,
   input logic [`LAT_TID_W-1:0]  tid_i,
   input logic [`LAT_META_W-1:0] meta_i
);

   localparam logic [2:0] FENCE_CODE = lat_pkg::WRFENCE;

   // Queues come out of reset empty
   reset_levels: assert property (@(posedge clk) rst |=> (!valid_i && empty_i && !full_i))
      else $error("valid_o, empty_o or full_o wrong after a reset cycle");

   // No error strobe straight after reset
   reset_strobes: assert property (@(posedge clk) rst |=> (!overflow_i && !underflow_i))
      else $error("error strobe high after a reset cycle");

   // Empty is the inverse of valid
   empty_mirror: assert property (@(posedge clk) disable iff (rst) empty_i == !valid_i)
      else $error("empty_o does not mirror valid_o");

   // Writer obeys full_o
   no_overflow: assert property (@(posedge clk) disable iff (rst) !overflow_i)
      else $error("overflow_o pulsed");

   // Reader only reads while valid_o is high
   no_underflow: assert property (@(posedge clk) disable iff (rst) !underflow_i)
      else $error("underflow_o pulsed");

   // Head entry stays put until it is read
   head_hold: assert property (@(posedge clk) disable iff (rst)
      (valid_i && !read_i) |=> (valid_i && $stable(tid_i) && $stable(meta_i)))
      else $error("output head changed without a read");

   // Fences are trapped before the slots
   no_fence_out: assert property (@(posedge clk) disable iff (rst)
      valid_i |-> (meta_i[2:0] != FENCE_CODE))
      else $error("fence request visible on meta_o");

endmodule

/* source/latency_model_top.sv */
`timescale 1ns/1ps
`include "lat_params.svh"

// Latency model for a memory request channel
module latency_model_top (
   input  logic                   clk,
   input  logic                   rst,
   // Writer side
   input  lat_pkg::req_t          req_i,
   input  logic                   write_i,
   output logic                   full_o,
   // Reader side
   output logic [`LAT_TID_W-1:0]  tid_o,
   output logic [`LAT_META_W-1:0] meta_o,
   output logic [`LAT_DATA_W-1:0] data_o,
   output logic                   valid_o,
   input  logic                   read_i,
   // Status
   output logic                   empty_o,
   output logic                   overflow_o,
   output logic                   underflow_o
);

   lat_pkg::req_t         in_head;
   logic                  in_valid;
   logic                  in_ovf;
   logic                  in_unf;
   lat_pkg::req_type_e    head_type;
   lat_pkg::tagged_t      slot_out;
   lat_pkg::tagged_t      out_head;
   logic                  out_almfull;
   logic                  out_ovf;
   logic                  out_unf;
   logic                  in_pop;
   logic                  slot_push;
   logic                  slot_pop;
   logic                  any_free;
   logic                  any_ready;
   logic                  all_idle;
   logic [`LAT_CTR_W-1:0] delay;

   // Input queue, almost full is the writer's stop level
   req_fifo #(
      .payload_t (lat_pkg::req_t)
   ) in_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_i        (write_i),
      .din_i       (req_i),
      .rd_i        (in_pop),
      .dout_o      (in_head),
      .valid_o     (in_valid),
      .almfull_o   (full_o),
      .overflow_o  (in_ovf),
      .underflow_o (in_unf)
   );

   // Type code sits in the low meta bits
   assign head_type = lat_pkg::req_type_e'(in_head.meta[2:0]);

   delay_gen delay_gen_i (
      .clk       (clk),
      .rst       (rst),
      .advance_i (slot_push),
      .type_i    (head_type),
      .delay_o   (delay)
   );

   slot_array slot_array_i (
      .clk         (clk),
      .rst         (rst),
      .push_i      (slot_push),
      .req_i       (in_head),
      .delay_i     (delay),
      .pop_i       (slot_pop),
      .out_o       (slot_out),
      .any_free_o  (any_free),
      .any_ready_o (any_ready),
      .all_idle_o  (all_idle)
   );

   flow_ctrl flow_ctrl_i (
      .clk           (clk),
      .rst           (rst),
      .head_valid_i  (in_valid),
      .head_type_i   (head_type),
      .any_free_i    (any_free),
      .any_ready_i   (any_ready),
      .all_idle_i    (all_idle),
      .out_empty_i   (!valid_o),
      .out_almfull_i (out_almfull),
      .in_pop_o      (in_pop),
      .slot_push_o   (slot_push),
      .slot_pop_o    (slot_pop)
   );

   // Output queue, order set by slot completion
   req_fifo #(
      .payload_t (lat_pkg::tagged_t)
   ) out_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_i        (slot_pop),
      .din_i       (slot_out),
      .rd_i        (read_i),
      .dout_o      (out_head),
      .valid_o     (valid_o),
      .almfull_o   (out_almfull),
      .overflow_o  (out_ovf),
      .underflow_o (out_unf)
   );

   assign tid_o  = out_head.tid;
   assign meta_o = out_head.req.meta;
   assign data_o = out_head.req.data;

   assign empty_o     = !valid_o;
   assign overflow_o  = in_ovf || out_ovf;
   assign underflow_o = in_unf || out_unf;

endmodule

/* source/flow_ctrl.sv */
`timescale 1ns/1ps
`include "lat_params.svh"

// Pop and push decisions plus fence trap
module flow_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  logic               head_valid_i,
   input  lat_pkg::req_type_e head_type_i,
   input  logic               any_free_i,
   input  logic               any_ready_i,
   input  logic               all_idle_i,
   input  logic               out_empty_i,
   input  logic               out_almfull_i,
   output logic               in_pop_o,
   output logic               slot_push_o,
   output logic               slot_pop_o
);

   typedef enum logic [1:0] {
      FC_PASS,
      FC_WAIT,
      FC_DROP
   } fence_state_e;

   fence_state_e state_q;
   logic         head_fence;
   logic         head_move;

   assign head_fence = head_valid_i && (head_type_i == lat_pkg::WRFENCE);

   // Ordinary head goes to a slot only in pass state
   assign head_move = (state_q == FC_PASS) && head_valid_i && !head_fence && any_free_i;

   // Fence leaves the input queue alone, no slot taken
   assign in_pop_o    = head_move || (state_q == FC_DROP && head_valid_i);
   assign slot_push_o = head_move;

   // Drain ready slots while the output queue has room
   assign slot_pop_o = any_ready_i && !out_almfull_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= FC_PASS;
      end else begin
         case (state_q)
            FC_PASS: begin
               // Fence at head blocks further pops
               if (head_fence) begin
                  state_q <= FC_WAIT;
               end
            end
            FC_WAIT: begin
               // Everything older has left slots and output queue
               if (all_idle_i && out_empty_i) begin
                  state_q <= FC_DROP;
               end
            end
            FC_DROP: state_q <= FC_PASS;
            default: state_q <= FC_PASS;
         endcase
      end
   end

endmodule

/* source/slot_array.sv */
`timescale 1ns/1ps
`include "lat_params.svh"

// Latency slots, each one counts down its own delay
module slot_array (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  push_i,
   input  lat_pkg::req_t         req_i,
   input  logic [`LAT_CTR_W-1:0] delay_i,
   input  logic                  pop_i,
   output lat_pkg::tagged_t      out_o,
   output logic                  any_free_o,
   output logic                  any_ready_o,
   output logic                  all_idle_o
);

   localparam int SLOTS = `LAT_SLOTS;
   localparam int IW    = $clog2(SLOTS);

   typedef enum logic [1:0] {
      SLOT_IDLE,
      SLOT_COUNT,
      SLOT_READY
   } slot_state_e;

   slot_state_e            state_q [SLOTS];
   logic [`LAT_CTR_W-1:0]  ctr_q [SLOTS];
   lat_pkg::tagged_t       entry_q [SLOTS];
   logic [`LAT_TID_W-1:0]  tid_q;
   logic [SLOTS-1:0]       idle_vec;
   logic [SLOTS-1:0]       ready_vec;
   logic [IW-1:0]          free_idx;
   logic [IW-1:0]          ready_idx;

   // Per-slot flags
   always_comb begin
      for (int i = 0; i < SLOTS; i++) begin
         idle_vec[i]  = (state_q[i] == SLOT_IDLE);
         ready_vec[i] = (state_q[i] == SLOT_READY);
      end
   end

   // Lowest free and lowest ready slot
   // Scan downwards so the last hit is the lowest index
   always_comb begin
      free_idx  = '0;
      ready_idx = '0;
      for (int i = SLOTS - 1; i >= 0; i--) begin
         if (idle_vec[i]) begin
            free_idx = IW'(i);
         end
         if (ready_vec[i]) begin
            ready_idx = IW'(i);
         end
      end
   end

   assign any_free_o  = |idle_vec;
   assign any_ready_o = |ready_vec;
   assign all_idle_o  = &idle_vec;
   assign out_o       = entry_q[ready_idx];

   // Payload and countdown
   always_ff @(posedge clk) begin
      for (int i = 0; i < SLOTS; i++) begin
         if (push_i && idle_vec[i] && free_idx == IW'(i)) begin
            entry_q[i] <= '{tid: tid_q, req: req_i};
            ctr_q[i]   <= delay_i;
         end else if (state_q[i] == SLOT_COUNT && ctr_q[i] != '0) begin
            ctr_q[i] <= ctr_q[i] - 1'b1;
         end
      end
   end

   // Slot states and tid counter
   always_ff @(posedge clk) begin
      if (rst) begin
         tid_q <= '0;
         for (int i = 0; i < SLOTS; i++) begin
            state_q[i] <= SLOT_IDLE;
         end
      end else begin
         // Tids count pushes, fences never get one
         if (push_i) begin
            tid_q <= tid_q + 1'b1;
         end
         for (int i = 0; i < SLOTS; i++) begin
            case (state_q[i])
               SLOT_IDLE: begin
                  if (push_i && free_idx == IW'(i)) begin
                     state_q[i] <= SLOT_COUNT;
                  end
               end
               SLOT_COUNT: begin
                  // Ready one cycle after reaching zero
                  if (ctr_q[i] == '0) begin
                     state_q[i] <= SLOT_READY;
                  end
               end
               SLOT_READY: begin
                  if (pop_i && ready_idx == IW'(i)) begin
                     state_q[i] <= SLOT_IDLE;
                  end
               end
               default: state_q[i] <= SLOT_IDLE;
            endcase
         end
      end
   end

endmodule

/* source/delay_gen.sv */
`timescale 1ns/1ps
`include "lat_params.svh"

// Pseudo-random delay per request type
module delay_gen (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   advance_i,
   input  lat_pkg::req_type_e     type_i,
   output logic [`LAT_CTR_W-1:0]  delay_o
);

   localparam int CTR_W = `LAT_CTR_W;

   // x^16 + x^14 + x^13 + x^11 + 1, right-shifting Galois form
   localparam logic [15:0] LFSR_TAPS = 16'hB400;
   localparam logic [15:0] LFSR_SEED = 16'hACE1;

   localparam logic [CTR_W-1:0] RDLINE_MIN  = `LAT_RDLINE_MIN;
   localparam logic [CTR_W-1:0] RDLINE_MASK = `LAT_RDLINE_MASK;
   localparam logic [CTR_W-1:0] WRLINE_MIN  = `LAT_WRLINE_MIN;
   localparam logic [CTR_W-1:0] WRLINE_MASK = `LAT_WRLINE_MASK;
   localparam logic [CTR_W-1:0] WRTHRU_MIN  = `LAT_WRTHRU_MIN;
   localparam logic [CTR_W-1:0] WRTHRU_MASK = `LAT_WRTHRU_MASK;
   localparam logic [CTR_W-1:0] INTR_MIN    = `LAT_INTR_MIN;
   localparam logic [CTR_W-1:0] INTR_MASK   = `LAT_INTR_MASK;
   localparam logic [CTR_W-1:0] UNDEF_DELAY = `LAT_UNDEF_DELAY;

   logic [15:0]      lfsr_q;
   logic [CTR_W-1:0] rnd;

   // One step per slot push
   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr_q <= LFSR_SEED;
      end else if (advance_i) begin
         lfsr_q <= {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 16'h0000);
      end
   end

   assign rnd = lfsr_q[CTR_W-1:0];

   always_comb begin
      case (type_i)
         lat_pkg::RDLINE: delay_o = RDLINE_MIN + (rnd & RDLINE_MASK);
         lat_pkg::WRLINE: delay_o = WRLINE_MIN + (rnd & WRLINE_MASK);
         lat_pkg::WRTHRU: delay_o = WRTHRU_MIN + (rnd & WRTHRU_MASK);
         lat_pkg::INTR:   delay_o = INTR_MIN + (rnd & INTR_MASK);
         // Fence is dropped before any push, lumped with unknown codes
         default:         delay_o = UNDEF_DELAY;
      endcase
   end

endmodule

/* source/req_fifo.sv */
`timescale 1ns/1ps
`include "lat_params.svh"

// Show-ahead queue, head visible while valid_o is high
module req_fifo #(
   parameter type payload_t = lat_pkg::req_t
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     wr_i,
   input  payload_t din_i,
   input  logic     rd_i,
   output payload_t dout_o,
   output logic     valid_o,
   output logic     almfull_o,
   output logic     overflow_o,
   output logic     underflow_o
);

   localparam int AW    = `LAT_FIFO_DEPTH_LOG2;
   localparam int DEPTH = 1 << AW;
   // Occupancy at which only the threshold of free entries is left
   localparam logic [AW:0] ALM_LEVEL = (AW+1)'(DEPTH - `LAT_FIFO_ALMFULL);

   payload_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          full;
   logic          empty;
   logic          do_wr;
   logic          do_rd;

   assign full  = (count == (AW+1)'(DEPTH));
   assign empty = (count == '0);

   // Bad accesses are dropped
   assign do_wr = wr_i && !full;
   assign do_rd = rd_i && !empty;

   // Head shown straight from storage
   assign dout_o    = mem[rd_ptr];
   assign valid_o   = !empty;
   assign almfull_o = (count >= ALM_LEVEL);

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Occupancy, unchanged on simultaneous push and pop
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // One-cycle error strobes
         overflow_o  <= wr_i && full;
         underflow_o <= rd_i && empty;
      end
   end

endmodule

/* source/lat_pkg.sv */
`include "lat_params.svh"

package lat_pkg;

   // Request type, low three bits of meta
   // Codes 5 to 7 are undefined types
   typedef enum logic [2:0] {
      RDLINE  = 3'd0,
      WRLINE  = 3'd1,
      WRTHRU  = 3'd2,
      WRFENCE = 3'd3,
      INTR    = 3'd4
   } req_type_e;

   // Request as written by the producer
   // Input queue payload, 48 bits
   typedef struct packed {
      logic [`LAT_META_W-1:0] meta;
      logic [`LAT_DATA_W-1:0] data;
   } req_t;

   // Request with its tracking id
   // Slot and output queue payload, 64 bits
   typedef struct packed {
      logic [`LAT_TID_W-1:0] tid;
      req_t                  req;
   } tagged_t;

endpackage

/* source/lat_params.svh */
`ifndef LAT_PARAMS_SVH
`define LAT_PARAMS_SVH

// Request fields
`define LAT_META_W 16
`define LAT_DATA_W 32
`define LAT_TID_W 16

// Latency slot array
`define LAT_SLOTS 8
`define LAT_CTR_W 6

// Queue geometry, almost full at this many free entries
`define LAT_FIFO_DEPTH_LOG2 3
`define LAT_FIFO_ALMFULL 2

// Per-type delay range, min plus (random & mask)
`define LAT_RDLINE_MIN 8
`define LAT_RDLINE_MASK 7
`define LAT_WRLINE_MIN 4
`define LAT_WRLINE_MASK 7
`define LAT_WRTHRU_MIN 4
`define LAT_WRTHRU_MASK 7
`define LAT_INTR_MIN 2
`define LAT_INTR_MASK 3
`define LAT_UNDEF_DELAY 20

`endif
